/* hdl/pluck_pkg.sv */
`default_nettype none

package pluck_pkg;

	// audio sample and stored word
	localparam int sample_w = 24;
	localparam int word_w = 32;

	// delay line geometry
	localparam int addr_w = 12;
	localparam int len_w = 11;

	// loop loses word >>> gain_shift per pass
	localparam int gain_shift = 10;

	typedef logic signed [sample_w-1:0] sample_t;

	// sample in the top bits over 8 fraction bits
	typedef logic signed [word_w-1:0] word_t;

	typedef logic [2:0] filt_sel_t;

	typedef struct packed {
		logic [len_w-1:0] delay_length; // loop period minus one
		filt_sel_t tone_sel; // first lowpass shift
		filt_sel_t decay_sel; // second lowpass shift
	} voice_ctrl_t;

endpackage

`default_nettype wire

/* hdl/trig_debounce.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_debounce
#(
	parameter int debounce_w = 2
)
(
	input wire a_clk,
	input wire reset_n,
	input wire trig,
	output logic pluck
);

	logic sync_0;
	logic sync_1;
	logic [debounce_w-1:0] stable_cnt; // also limits tempo
	logic pressed; // debounced button state
	logic pressed_d;
	logic idle;
	logic cnt_max;

	assign idle = (pressed == sync_1); // input agrees with state
	assign cnt_max = &stable_cnt;

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			sync_0 <= 1'b0;
			sync_1 <= 1'b0;
			stable_cnt <= '0;
			pressed <= 1'b0;
			pressed_d <= 1'b0;
			pluck <= 1'b0;
		end
		else
		begin
			sync_0 <= ~trig; // active low trigger
			sync_1 <= sync_0;
			if (idle)
			begin
				stable_cnt <= '0;
			end
			else
			begin
				stable_cnt <= stable_cnt + 1'b1;
				if (cnt_max)
				begin
					pressed <= ~pressed; // held long enough
				end
			end
			pressed_d <= pressed;
			pluck <= pressed & ~pressed_d; // press edge only
		end
	end

endmodule

`default_nettype wire

/* hdl/delay_line_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_line_ram
#(
	parameter int depth_w = pluck_pkg::addr_w
)
(
	input wire a_clk,
	input wire reset_n,
	input wire [depth_w-1:0] wr_addr,
	input wire [depth_w-1:0] rd_addr,
	input wire pluck_pkg::word_t wr_data,
	input wire rd_en,
	output pluck_pkg::word_t rd_data
);

	pluck_pkg::word_t mem [0:(1<<depth_w)-1];

	// write port, always enabled
	always_ff @(posedge a_clk)
	begin
		mem[wr_addr] <= wr_data;
	end

	// read returns the old word on a same address write
	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			rd_data <= '0;
		end
		else if (rd_en)
		begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

/* hdl/loop_lowpass.sv */
`timescale 1ns/1ps
`default_nettype none

module loop_lowpass
(
	input wire a_clk,
	input wire reset_n,
	input wire pluck_pkg::filt_sel_t sel,
	input wire pluck_pkg::sample_t d,
	output pluck_pkg::sample_t q
);

	localparam int ext_w = pluck_pkg::sample_w + 1;

	logic signed [ext_w-1:0] d_ext;
	logic signed [ext_w-1:0] q_ext;
	logic signed [ext_w-1:0] diff; // extra bit avoids overflow
	logic signed [ext_w-1:0] step;
	logic signed [ext_w-1:0] next_q;

	assign d_ext = {d[pluck_pkg::sample_w-1], d};
	assign q_ext = {q[pluck_pkg::sample_w-1], q};
	assign diff = d_ext - q_ext;
	assign step = diff >>> sel;

	// stays between old output and input
	assign next_q = q_ext + step;

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			q <= '0;
		end
		else
		begin
			q <= next_q[pluck_pkg::sample_w-1:0];
		end
	end

endmodule

`default_nettype wire

/* hdl/string_voice.sv */
`timescale 1ns/1ps
`default_nettype none

module string_voice
#(
	parameter int depth_w = pluck_pkg::addr_w
)
(
	input wire a_clk,
	input wire reset_n,
	input wire pluck,
	input wire pluck_pkg::sample_t noise,
	input wire pluck_pkg::voice_ctrl_t ctrl,
	output pluck_pkg::sample_t sample_out,
	output logic exciting
);

	localparam int frac_w = pluck_pkg::word_w - pluck_pkg::sample_w;

	typedef enum logic [1:0]
	{
		st_idle,
		st_excite,
		st_ring
	} state_t;

	state_t state;
	logic [pluck_pkg::len_w-1:0] count;
	logic at_end;
	logic [depth_w-1:0] addr;
	logic rd_en;
	pluck_pkg::word_t wr_data;
	pluck_pkg::word_t rd_data;
	pluck_pkg::word_t gained;
	pluck_pkg::sample_t loop_in;
	pluck_pkg::sample_t tone_q;
	pluck_pkg::sample_t decay_q;

	assign at_end = (count == ctrl.delay_length);
	assign addr = depth_w'(count); // shared read and write address
	assign exciting = (state == st_excite);
	assign rd_en = (state == st_ring);

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			state <= st_idle;
			count <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (pluck)
					begin
						state <= st_excite;
						count <= '0;
					end
				end
				st_excite:
				begin
					if (at_end) // line full of noise
					begin
						state <= st_ring;
						count <= '0;
					end
					else
					begin
						count <= count + 1'b1;
					end
				end
				st_ring:
				begin
					if (pluck) // pluck again
					begin
						state <= st_excite;
						count <= '0;
					end
					else if (at_end)
					begin
						count <= '0;
					end
					else
					begin
						count <= count + 1'b1;
					end
				end
				default:
				begin
					state <= st_idle;
					count <= '0;
				end
			endcase
		end
	end

	// noise fills the line, then the loop recirculates
	assign wr_data = exciting ? {noise, {frac_w{1'b0}}} : {decay_q, {frac_w{1'b0}}};

	delay_line_ram
	#(
		.depth_w(depth_w)
	)
	i_delay_line_ram
	(
		.a_clk(a_clk),
		.reset_n(reset_n),
		.wr_addr(addr),
		.rd_addr(addr),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_data(rd_data)
	);

	assign gained = rd_data - (rd_data >>> pluck_pkg::gain_shift); // small loss per pass
	assign loop_in = gained[pluck_pkg::word_w-1 -: pluck_pkg::sample_w];

	loop_lowpass tone_filt
	(
		.a_clk(a_clk),
		.reset_n(reset_n),
		.sel(ctrl.tone_sel),
		.d(loop_in),
		.q(tone_q)
	);

	loop_lowpass decay_filt
	(
		.a_clk(a_clk),
		.reset_n(reset_n),
		.sel(ctrl.decay_sel),
		.d(tone_q),
		.q(decay_q)
	);

	assign sample_out = decay_q;

endmodule

`default_nettype wire

/* hdl/pluck_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pluck_top
#(
	parameter int debounce_w = 2,
	parameter int depth_w = pluck_pkg::addr_w
)
(
	input wire a_clk,
	input wire reset_n,
	input wire trig,
	input wire pluck_pkg::sample_t noise,
	input wire pluck_pkg::voice_ctrl_t ctrl,
	output pluck_pkg::sample_t sample_out,
	output logic exciting
);

	logic pluck; // one cycle per press

	trig_debounce
	#(
		.debounce_w(debounce_w)
	)
	i_trig_debounce
	(
		.a_clk(a_clk),
		.reset_n(reset_n),
		.trig(trig),
		.pluck(pluck)
	);

	string_voice
	#(
		.depth_w(depth_w)
	)
	i_string_voice
	(
		.a_clk(a_clk),
		.reset_n(reset_n),
		.pluck(pluck),
		.noise(noise),
		.ctrl(ctrl),
		.sample_out(sample_out),
		.exciting(exciting)
	);

endmodule

`default_nettype wire

/* tb/pluck_tb_checks.svh */
`ifndef PLUCK_TB_CHECKS_SVH
`define PLUCK_TB_CHECKS_SVH

int check_errs = 0; // failures in the running test
int tests_run = 0;
int tests_failed = 0;

task automatic check_sample(input string name, input pluck_pkg::sample_t got,
	input pluck_pkg::sample_t exp);
	if (got !== exp)
	begin
		$display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
		check_errs++;
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
		check_errs++;
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp)
	begin
		$display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
		check_errs++;
	end
endtask

// anything that is not a wrong value
task automatic report_failure(input string what);
	$display("failure at t=%0t: %s", $time, what);
	check_errs++;
endtask

task automatic close_test(input string name);
	tests_run++;
	if (check_errs == 0)
	begin
		$display("test %0d (%s): ok", tests_run, name);
	end
	else
	begin
		$display("test %0d (%s): failed with %0d errors", tests_run, name, check_errs);
		tests_failed++;
	end
	check_errs = 0;
endtask

task automatic print_counts();
	$display("%0d tests run, %0d passed, %0d failed", tests_run,
		tests_run - tests_failed, tests_failed);
endtask

`endif

/* tb/pluck_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pluck_tb;

	logic a_clk;
	logic reset_n;
	logic trig;
	pluck_pkg::sample_t noise;
	pluck_pkg::voice_ctrl_t ctrl;
	pluck_pkg::sample_t sample_out;
	logic exciting;

	int fd;
	bit aborted; // set once a wait runs out
	pluck_pkg::sample_t noise_buf [4];
	pluck_pkg::sample_t exp_buf [14];
	int exp_count;

	pluck_top
	#(
		.debounce_w(2),
		.depth_w(pluck_pkg::addr_w)
	)
	i_pluck_top
	(
		.a_clk(a_clk),
		.reset_n(reset_n),
		.trig(trig),
		.noise(noise),
		.ctrl(ctrl),
		.sample_out(sample_out),
		.exciting(exciting)
	);

	`include "pluck_tb_checks.svh"

	initial
	begin
		a_clk = 1'b0;
		forever #4 a_clk = ~a_clk;
	end

	// skips comments and blank lines
	task automatic next_line(output string s);
		int r;
		s = "";
		while (fd != 0 && !$feof(fd))
		begin
			r = $fgets(s, fd);
			if (r > 1 && s.getc(0) != "#")
			begin
				return;
			end
		end
		s = "";
		report_failure("golden file ended before all tests were read");
		aborted = 1'b1;
	endtask

	task automatic read_ctrl();
		string s;
		int dl;
		int ts;
		int ds;
		next_line(s);
		if ($sscanf(s, "c %d %d %d", dl, ts, ds) != 3)
		begin
			report_failure("bad ctrl line in golden file");
			aborted = 1'b1;
		end
		ctrl.delay_length = pluck_pkg::len_w'(dl);
		ctrl.tone_sel = 3'(ts);
		ctrl.decay_sel = 3'(ds);
	endtask

	task automatic read_noise();
		string s;
		int v [4];
		next_line(s);
		if ($sscanf(s, "n %d %d %d %d", v[0], v[1], v[2], v[3]) != 4)
		begin
			report_failure("bad noise line in golden file");
			aborted = 1'b1;
		end
		for (int i = 0; i < 4; i++)
		begin
			noise_buf[i] = pluck_pkg::sample_t'(v[i]);
		end
	endtask

	task automatic read_expect();
		string s;
		int v [7];
		for (int l = 0; l < 2; l++)
		begin
			next_line(s);
			if ($sscanf(s, "e %d %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5],
				v[6]) != 7)
			begin
				report_failure("bad expected line in golden file");
				aborted = 1'b1;
			end
			for (int i = 0; i < 7; i++)
			begin
				exp_buf[l*7+i] = pluck_pkg::sample_t'(v[i]);
			end
		end
	endtask

	task automatic read_count();
		string s;
		next_line(s);
		if ($sscanf(s, "k %d", exp_count) != 1)
		begin
			report_failure("bad count line in golden file");
			aborted = 1'b1;
		end
	endtask

	task automatic apply_reset();
		@(negedge a_clk);
		reset_n = 1'b1; // high asserts reset
		repeat (8) @(negedge a_clk);
		reset_n = 1'b0;
	endtask

	// press, then feed noise while the line fills
	task automatic press_and_excite(input bit zero_noise, output int len);
		int wait_cnt;
		int idx;
		len = 0;
		idx = 0;
		wait_cnt = 0;
		trig = 1'b0;
		while (!exciting && wait_cnt < 40)
		begin
			@(negedge a_clk);
			wait_cnt++;
		end
		if (!exciting)
		begin
			report_failure("exciting never rose after the trigger was pressed");
			aborted = 1'b1;
			return;
		end
		wait_cnt = 0;
		while (exciting && wait_cnt < 4096)
		begin
			noise = (zero_noise || idx > 3) ? '0 : noise_buf[idx];
			idx++;
			len++;
			@(negedge a_clk);
			wait_cnt++;
		end
		if (exciting)
		begin
			report_failure("exciting stayed high and never fell");
			aborted = 1'b1;
		end
		noise = '0;
	endtask

	task automatic check_ring(input int n);
		for (int i = 0; i < n; i++)
		begin
			check_sample("sample_out", sample_out, exp_buf[i]);
			@(negedge a_clk);
		end
	endtask

	initial
	begin
		int len;
		int rises;
		logic prev;
		trig = 1'b1;
		noise = '0;
		ctrl = '0;
		reset_n = 1'b1;
		aborted = 1'b0;
		fd = $fopen("tb/pluck_golden.txt", "r");
		if (fd == 0)
		begin
			report_failure("cannot open tb/pluck_golden.txt");
			aborted = 1'b1;
		end
		apply_reset();

		for (int i = 0; i < 20; i++)
		begin
			check_sample("sample_out", sample_out, '0);
			check_flag("exciting", exciting, 1'b0);
			@(negedge a_clk);
		end
		close_test("idle after reset");

		if (!aborted)
		begin
			read_ctrl();
			read_count();
			apply_reset();
			trig = 1'b0; // glitch shorter than the window
			repeat (2) @(negedge a_clk);
			trig = 1'b1;
			for (int i = 0; i < 30; i++)
			begin
				check_flag("exciting", exciting, 1'b0);
				@(negedge a_clk);
			end
			press_and_excite(1'b1, len);
			trig = 1'b1;
			check_count("exciting cycles", len, exp_count);
			close_test("debounce and excite length");
		end

		for (int t = 0; t < 2; t++)
		begin
			if (!aborted)
			begin
				read_ctrl();
				read_noise();
				read_expect();
				apply_reset();
				press_and_excite(1'b0, len);
				if (!aborted)
				begin
					check_ring(14);
				end
				trig = 1'b1;
				close_test(t == 0 ? "ring without filtering" : "ring with lowpass");
			end
		end

		if (!aborted)
		begin
			read_ctrl();
			read_noise();
			read_expect();
			apply_reset();
			press_and_excite(1'b1, len); // silent first pluck
			trig = 1'b1;
			repeat (20) @(negedge a_clk);
			check_flag("exciting", exciting, 1'b0);
			if (!aborted)
			begin
				press_and_excite(1'b0, len);
			end
			if (!aborted)
			begin
				check_ring(14);
			end
			trig = 1'b1;
			close_test("second pluck while ringing");
		end

		if (!aborted)
		begin
			read_ctrl();
			read_count();
			apply_reset();
			rises = 0;
			prev = exciting;
			for (int i = 0; i < 130; i++)
			begin
				trig = (i < 100) ? 1'b0 : 1'b1;
				@(negedge a_clk);
				if (exciting && !prev)
				begin
					rises++;
				end
				prev = exciting;
			end
			check_count("excitations", rises, exp_count);
			close_test("long hold plucks once");
		end

		if (fd != 0)
		begin
			$fclose(fd);
		end
		print_counts();
		if (tests_failed == 0 && !aborted)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/pluck_golden.txt */
# c: delay_length tone_sel decay_sel   n: four noise samples, one per excite cycle
# e: seven expected sample_out values from the first ring cycle on   k: expected count
# debounce and excite length
c 9 0 0
k 10
# ring without filtering
c 3 0 0
n 1000 -500 4 2000
e 0 0 0 999 -500 3 1998
e 0 0 0 998 -500 3 1996
# ring with both lowpass shifts at 1
c 3 1 1
n 4096 0 -4096 0
e 0 0 0 1023 1023 -256 -512
e -448 -320 -208 127 434 338 101
# second pluck while ringing, first pluck uses zero noise
c 3 0 0
n 300 -4 7 -1200
e 0 0 0 299 -4 6 -1199
e 0 0 0 298 -4 5 -1198
# long hold
c 5 0 0
k 1

/* list.f */
+incdir+tb
hdl/pluck_pkg.sv
hdl/trig_debounce.sv
hdl/delay_line_ram.sv
hdl/loop_lowpass.sv
hdl/string_voice.sv
hdl/pluck_top.sv
tb/pluck_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module pluck_tb -Mdir obj_dir
	./obj_dir/Vpluck_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
